// File: hw/riscv_pkg.sv
// shared widths, field types and encodings for the back half of the rv32i pipeline; import where needed
package riscv_pkg;

	localparam int XLEN = 32;

	// data memory geometry, in words
	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = 8;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      rd_addr_t;
	typedef logic [2:0]      func3_t;
	typedef logic [3:0]      byte_sel_t; // bit n enables byte n
	typedef logic [1:0]      wb_src_t;

	// writeback source select
	localparam wb_src_t WB_ALU   = 2'd0;
	localparam wb_src_t WB_MEM   = 2'd1;
	localparam wb_src_t WB_PC4   = 2'd2; // jal, jalr
	localparam wb_src_t WB_PCIMM = 2'd3; // auipc

	// load func3 codes
	localparam func3_t F3_LB  = 3'd0;
	localparam func3_t F3_LH  = 3'd1;
	localparam func3_t F3_LW  = 3'd2;
	localparam func3_t F3_LBU = 3'd4;
	localparam func3_t F3_LHU = 3'd5;

endpackage

// File: hw/riscv_em_if.sv
// execute/memory register contents, driven by the em register and read by the memory stage
`timescale 1ns/100ps

interface riscv_em_if;
	import riscv_pkg::*;

	wb_src_t   wb_src;
	logic      reg_wr_en;
	logic      mem_wr_en;
	byte_sel_t mem_byte_sel;
	xlen_t     alu_result; // also the memory address
	xlen_t     write_data; // already shifted into its lane
	rd_addr_t  rd_addr;
	func3_t    func3;
	xlen_t     pcplus4;
	xlen_t     pc_plus_imm;

	modport em_src (
		output wb_src, reg_wr_en, mem_wr_en, mem_byte_sel, alu_result,
		output write_data, rd_addr, func3, pcplus4, pc_plus_imm
	);

	modport mem_dst (
		input wb_src, reg_wr_en, mem_wr_en, mem_byte_sel, alu_result,
		input write_data, rd_addr, func3, pcplus4, pc_plus_imm
	);

endinterface

// File: hw/riscv_em_register.sv
// execute/memory pipeline register; loads on every edge with i_em_en high, holds otherwise
`timescale 1ns/100ps

module riscv_em_register (
	input  logic                i_clk,
	input  logic                i_rstn,
	input  logic                i_em_en,
	input  riscv_pkg::wb_src_t   i_wb_src,
	input  logic                i_reg_wr_en,
	input  logic                i_mem_wr_en,
	input  logic                i_is_load,
	input  riscv_pkg::byte_sel_t i_mem_byte_sel,
	input  riscv_pkg::xlen_t     i_alu_result,
	input  riscv_pkg::xlen_t     i_write_data,
	input  riscv_pkg::xlen_t     i_pcplus4,
	input  riscv_pkg::xlen_t     i_pc_plus_imm,
	input  riscv_pkg::rd_addr_t  i_rd_addr,
	input  riscv_pkg::func3_t    i_func3,
	output logic                o_is_load,
	riscv_em_if.em_src          em
);
	import riscv_pkg::*;

	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			em.wb_src       <= WB_ALU;
			em.reg_wr_en    <= 1'b0;
			em.mem_wr_en    <= 1'b0;
			em.mem_byte_sel <= '0;
			em.alu_result   <= '0;
			em.write_data   <= '0;
			em.rd_addr      <= '0;
			em.func3        <= '0;
			em.pcplus4      <= '0;
			em.pc_plus_imm  <= '0;
			o_is_load       <= 1'b0;
		end else if (i_em_en) begin // low en keeps the instruction in place
			em.wb_src       <= i_wb_src;
			em.reg_wr_en    <= i_reg_wr_en;
			em.mem_wr_en    <= i_mem_wr_en;
			em.mem_byte_sel <= i_mem_byte_sel;
			em.alu_result   <= i_alu_result;
			em.write_data   <= i_write_data;
			em.rd_addr      <= i_rd_addr;
			em.func3        <= i_func3;
			em.pcplus4      <= i_pcplus4;
			em.pc_plus_imm  <= i_pc_plus_imm;
			o_is_load       <= i_is_load;
		end
	end

endmodule

// File: hw/riscv_dmem.sv
// word-organised data memory; combinational word read, byte-lane write on the clock edge
`timescale 1ns/100ps

module riscv_dmem (
	input  logic                i_clk,
	input  logic                i_wr_en,
	input  riscv_pkg::byte_sel_t i_byte_sel,
	input  riscv_pkg::xlen_t     i_addr,
	input  riscv_pkg::xlen_t     i_wr_data,
	output riscv_pkg::xlen_t     o_rd_data
);
	import riscv_pkg::*;

	xlen_t                mem [DMEM_WORDS];
	logic [DMEM_AW-1:0]  word_addr;

	// byte offset is handled by the load aligner
	assign word_addr = i_addr[DMEM_AW+1:2];

	always_ff @(posedge i_clk) begin
		if (i_wr_en) begin
			for (int b = 0; b < XLEN/8; b++) begin
				if (i_byte_sel[b])
					mem[word_addr][b*8 +: 8] <= i_wr_data[b*8 +: 8];
			end
		end
	end

	assign o_rd_data = mem[word_addr]; // whole word, no latency

endmodule

// File: hw/riscv_load_align.sv
// picks the addressed byte or halfword out of a loaded word and extends it per func3
`timescale 1ns/100ps

module riscv_load_align (
	input  riscv_pkg::xlen_t  i_rd_word,
	input  logic [1:0]        i_byte_off,
	input  riscv_pkg::func3_t i_func3,
	output riscv_pkg::xlen_t  o_load_data
);
	import riscv_pkg::*;

	logic [7:0]  sel_byte;
	logic [15:0] sel_half;

	always_comb begin
		case (i_byte_off)
			2'd0:    sel_byte = i_rd_word[7:0];
			2'd1:    sel_byte = i_rd_word[15:8];
			2'd2:    sel_byte = i_rd_word[23:16];
			default: sel_byte = i_rd_word[31:24];
		endcase
	end

	// halfwords sit at offset 0 or 2 only
	assign sel_half = i_byte_off[1] ? i_rd_word[31:16] : i_rd_word[15:0];

	always_comb begin
		case (i_func3)
			F3_LB:   o_load_data = {{(XLEN-8){sel_byte[7]}}, sel_byte};
			F3_LH:   o_load_data = {{(XLEN-16){sel_half[15]}}, sel_half};
			F3_LBU:  o_load_data = {{(XLEN-8){1'b0}}, sel_byte};
			F3_LHU:  o_load_data = {{(XLEN-16){1'b0}}, sel_half};
			F3_LW:   o_load_data = i_rd_word;
			default: o_load_data = i_rd_word; // not a load width, word passes
		endcase
	end

endmodule

// File: hw/riscv_mem_wb.sv
// writeback source mux followed by the memory/writeback pipeline register
`timescale 1ns/100ps

module riscv_mem_wb (
	input  logic                i_clk,
	input  logic                i_rstn,
	input  riscv_pkg::xlen_t    i_load_data,
	riscv_em_if.mem_dst         em,
	output logic                o_wb_reg_wr_en,
	output riscv_pkg::rd_addr_t o_wb_rd_addr,
	output riscv_pkg::xlen_t    o_wb_data
);
	import riscv_pkg::*;

	xlen_t wb_next;

	always_comb begin
		case (em.wb_src)
			WB_MEM:   wb_next = i_load_data;
			WB_PC4:   wb_next = em.pcplus4;
			WB_PCIMM: wb_next = em.pc_plus_imm;
			default:  wb_next = em.alu_result; // WB_ALU
		endcase
	end

	// always advances; a held em stage simply repeats here
	always_ff @(posedge i_clk or negedge i_rstn) begin
		if (!i_rstn) begin
			o_wb_reg_wr_en <= 1'b0;
			o_wb_rd_addr   <= '0;
			o_wb_data      <= '0;
		end else begin
			o_wb_reg_wr_en <= em.reg_wr_en;
			o_wb_rd_addr   <= em.rd_addr;
			o_wb_data      <= wb_next;
		end
	end

endmodule

// File: hw/riscv_back_end.sv
// top of the em register, memory stage and mem/wb register; execute results in, rf write port out
`timescale 1ns/100ps

module riscv_back_end (
	input  logic                 i_clk,
	input  logic                 i_rstn,
	input  logic                 i_em_en,
	input  riscv_pkg::wb_src_t   i_wb_src,
	input  logic                 i_reg_wr_en,
	input  logic                 i_mem_wr_en,
	input  logic                 i_is_load,
	input  riscv_pkg::byte_sel_t i_mem_byte_sel,
	input  riscv_pkg::xlen_t     i_alu_result,
	input  riscv_pkg::xlen_t     i_write_data,
	input  riscv_pkg::xlen_t     i_pcplus4,
	input  riscv_pkg::xlen_t     i_pc_plus_imm,
	input  riscv_pkg::rd_addr_t  i_rd_addr,
	input  riscv_pkg::func3_t    i_func3,
	// register file write port
	output logic                 o_wb_reg_wr_en,
	output riscv_pkg::rd_addr_t  o_wb_rd_addr,
	output riscv_pkg::xlen_t     o_wb_data,
	// mem stage fields for forwarding and hazard detection
	output riscv_pkg::rd_addr_t  o_em_rd_addr,
	output logic                 o_em_reg_wr_en,
	output logic                 o_em_is_load
);
	import riscv_pkg::*;

	xlen_t rd_word;
	xlen_t load_data;

	riscv_em_if em_bus ();

	riscv_em_register u_em_register (
		.i_clk          (i_clk),
		.i_rstn         (i_rstn),
		.i_em_en        (i_em_en),
		.i_wb_src       (i_wb_src),
		.i_reg_wr_en    (i_reg_wr_en),
		.i_mem_wr_en    (i_mem_wr_en),
		.i_is_load      (i_is_load),
		.i_mem_byte_sel (i_mem_byte_sel),
		.i_alu_result   (i_alu_result),
		.i_write_data   (i_write_data),
		.i_pcplus4      (i_pcplus4),
		.i_pc_plus_imm  (i_pc_plus_imm),
		.i_rd_addr      (i_rd_addr),
		.i_func3        (i_func3),
		.o_is_load      (o_em_is_load),
		.em             (em_bus.em_src)
	);

	// alu result is the effective address
	riscv_dmem u_dmem (
		.i_clk      (i_clk),
		.i_wr_en    (em_bus.mem_wr_en),
		.i_byte_sel (em_bus.mem_byte_sel),
		.i_addr     (em_bus.alu_result),
		.i_wr_data  (em_bus.write_data),
		.o_rd_data  (rd_word)
	);

	riscv_load_align u_load_align (
		.i_rd_word   (rd_word),
		.i_byte_off  (em_bus.alu_result[1:0]),
		.i_func3     (em_bus.func3),
		.o_load_data (load_data)
	);

	riscv_mem_wb u_mem_wb (
		.i_clk          (i_clk),
		.i_rstn         (i_rstn),
		.i_load_data    (load_data),
		.em             (em_bus.mem_dst),
		.o_wb_reg_wr_en (o_wb_reg_wr_en),
		.o_wb_rd_addr   (o_wb_rd_addr),
		.o_wb_data      (o_wb_data)
	);

	assign o_em_rd_addr   = em_bus.rd_addr;
	assign o_em_reg_wr_en = em_bus.reg_wr_en;

endmodule

// File: sim/riscv_back_end_assertions.sv
// concurrent checks on the back end, attached to riscv_back_end by the bind at the bottom
`timescale 1ns/100ps

module riscv_back_end_assertions (
	input logic                i_clk,
	input logic                i_rstn,
	input logic                i_em_en,
	input logic                i_reg_wr_en,
	input logic                i_mem_wr_en,
	input logic                i_wb_reg_wr_en,
	input logic                i_em_reg_wr_en,
	input logic                i_em_is_load,
	input riscv_pkg::rd_addr_t i_em_rd_addr
);
	int fail_cnt = 0; // failures seen so far

	no_write_in_reset: assert property (@(posedge i_clk)
		!i_rstn |-> !i_mem_wr_en && !i_wb_reg_wr_en && !i_em_reg_wr_en)
	else begin
		$error("write enable active while reset is asserted");
		fail_cnt++;
	end

	// two edges from execute inputs to the rf write port
	wb_follows_ex: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_em_en |-> ##2 (i_wb_reg_wr_en == $past(i_reg_wr_en, 2)))
	else begin
		$error("o_wb_reg_wr_en does not follow i_reg_wr_en two edges later");
		fail_cnt++;
	end

	em_held_stable: assert property (@(posedge i_clk) disable iff (!i_rstn)
		!i_em_en |=> $stable(i_em_rd_addr) && $stable(i_em_reg_wr_en) && $stable(i_em_is_load))
	else begin
		$error("em stage outputs changed while i_em_en was low");
		fail_cnt++;
	end

endmodule

bind riscv_back_end riscv_back_end_assertions u_assertions (
	.i_clk          (i_clk),
	.i_rstn         (i_rstn),
	.i_em_en        (i_em_en),
	.i_reg_wr_en    (i_reg_wr_en),
	.i_mem_wr_en    (em_bus.mem_wr_en),
	.i_wb_reg_wr_en (o_wb_reg_wr_en),
	.i_em_reg_wr_en (o_em_reg_wr_en),
	.i_em_is_load   (o_em_is_load),
	.i_em_rd_addr   (o_em_rd_addr)
);

// File: sim/riscv_back_end_tb.sv
// table-driven testbench for riscv_back_end; one entry per clock, wb outputs checked two edges later
`timescale 1ns/100ps

module riscv_back_end_tb;
	import riscv_pkg::*;

	typedef struct packed {
		logic      en;
		wb_src_t   wb_src;
		logic      reg_wr_en;
		logic      mem_wr_en;
		logic      is_load;
		byte_sel_t sel;
		xlen_t     alu;
		xlen_t     wdata;
		xlen_t     pc4;
		xlen_t     pcimm;
		rd_addr_t  rd;
		func3_t    f3;
		logic      exp_wr_en;
		rd_addr_t  exp_rd;
		xlen_t     exp_data;
		logic      exp_load;
	} stim_t;

	logic      i_clk;
	logic      i_rstn;
	logic      i_em_en;
	wb_src_t   i_wb_src;
	logic      i_reg_wr_en;
	logic      i_mem_wr_en;
	logic      i_is_load;
	byte_sel_t i_mem_byte_sel;
	xlen_t     i_alu_result;
	xlen_t     i_write_data;
	xlen_t     i_pcplus4;
	xlen_t     i_pc_plus_imm;
	rd_addr_t  i_rd_addr;
	func3_t    i_func3;
	logic      o_wb_reg_wr_en;
	rd_addr_t  o_wb_rd_addr;
	xlen_t     o_wb_data;
	rd_addr_t  o_em_rd_addr;
	logic      o_em_reg_wr_en;
	logic      o_em_is_load;

	stim_t    table_q[$];
	string    names[$];
	xlen_t    ref_mem [DMEM_WORDS]; // reference memory model
	integer   seed = 32'h8457;
	logic     last_wr_en = 1'b0; // wb state after reset
	rd_addr_t last_rd = '0;
	xlen_t    last_data = '0;
	logic     last_load = 1'b0;
	int       em_bad = 0;
	int       cycle_cnt = 0;
	int       cycle_limit;
	int       test_cnt = 0;
	int       fail_tests = 0;
	int       mismatches = 0;

	riscv_back_end dut (.*);

	always #50 i_clk = ~i_clk;

	always @(posedge i_clk) begin
		cycle_cnt++;
		if (cycle_cnt > cycle_limit) begin
			$display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
			$display("Errors found");
			$finish;
		end
	end

	function automatic xlen_t expect_load(xlen_t word, logic [1:0] off, func3_t f3);
		xlen_t shifted;
		shifted = word >> (8 * off);
		case (f3)
			F3_LB:   return xlen_t'($signed(shifted[7:0]));
			F3_LH:   return xlen_t'($signed(shifted[15:0]));
			F3_LBU:  return xlen_t'(shifted[7:0]);
			F3_LHU:  return xlen_t'(shifted[15:0]);
			default: return word;
		endcase
	endfunction

	function automatic stim_t base_op(wb_src_t src, rd_addr_t rd, xlen_t alu);
		stim_t e;
		e = '0;
		e.en = 1'b1;
		e.wb_src = src;
		e.reg_wr_en = 1'b1;
		e.rd = rd;
		e.alu = alu;
		e.wdata = $random(seed); // distractors, must not reach wb
		e.pc4 = $random(seed);
		e.pcimm = $random(seed);
		return e;
	endfunction

	function automatic stim_t store_op(xlen_t addr, xlen_t data, byte_sel_t sel);
		stim_t e;
		e = base_op(WB_ALU, '0, addr);
		e.reg_wr_en = 1'b0;
		e.mem_wr_en = 1'b1;
		e.sel = sel;
		e.wdata = data;
		return e;
	endfunction

	function automatic stim_t load_op(rd_addr_t rd, xlen_t addr, func3_t f3);
		stim_t e;
		e = base_op(WB_MEM, rd, addr);
		e.is_load = 1'b1;
		e.f3 = f3;
		return e;
	endfunction

	// disabled entry carrying a full store and rf write that must never land
	function automatic stim_t hold_op(xlen_t addr);
		stim_t e;
		e = store_op(addr, $random(seed), 4'hf);
		e.reg_wr_en = 1'b1;
		e.rd = 5'd31;
		e.en = 1'b0;
		return e;
	endfunction

	task automatic add_entry(stim_t e, string name);
		xlen_t mask;
		xlen_t ld;
		int    wa;
		wa = e.alu[DMEM_AW+1:2];
		if (e.en) begin
			ld = expect_load(ref_mem[wa], e.alu[1:0], e.f3); // read sees memory before own store
			mask = {{8{e.sel[3]}}, {8{e.sel[2]}}, {8{e.sel[1]}}, {8{e.sel[0]}}};
			if (e.mem_wr_en)
				ref_mem[wa] = (ref_mem[wa] & ~mask) | (e.wdata & mask);
			case (e.wb_src)
				WB_MEM:   last_data = ld;
				WB_PC4:   last_data = e.pc4;
				WB_PCIMM: last_data = e.pcimm;
				default:  last_data = e.alu;
			endcase
			last_wr_en = e.reg_wr_en;
			last_rd = e.rd;
			last_load = e.is_load;
		end
		e.exp_wr_en = last_wr_en; // held entries repeat the last capture
		e.exp_rd = last_rd;
		e.exp_data = last_data;
		e.exp_load = last_load;
		table_q.push_back(e);
		names.push_back(name);
	endtask

	task automatic build_table();
		xlen_t hi_word;
		add_entry(base_op(WB_ALU, 5'd1, $random(seed)), "alu");
		add_entry(base_op(WB_ALU, 5'd2, $random(seed)), "alu");
		add_entry(base_op(WB_ALU, 5'd3, $random(seed)), "alu");
		add_entry(base_op(WB_PC4, 5'd1, $random(seed)), "jal");
		add_entry(base_op(WB_PC4, 5'd4, $random(seed)), "jalr");
		add_entry(base_op(WB_PCIMM, 5'd5, $random(seed)), "auipc");
		add_entry(base_op(WB_PCIMM, 5'd6, $random(seed)), "auipc");
		// byte lane merges into one word
		add_entry(store_op(32'h40, $random(seed), 4'b1111), "sw");
		add_entry(store_op(32'h40, $random(seed), 4'b0010), "sb");
		add_entry(load_op(5'd8, 32'h40, F3_LW), "lw merge");
		add_entry(store_op(32'h40, $random(seed), 4'b1100), "sh");
		add_entry(load_op(5'd9, 32'h40, F3_LW), "lw merge");
		add_entry(store_op(32'h3fc, $random(seed), 4'b1111), "sw top");
		add_entry(load_op(5'd10, 32'h3fc, F3_LW), "lw next");
		hi_word = $random(seed) | 32'h8080_8080; // every byte negative
		add_entry(store_op(32'h200, hi_word, 4'b1111), "sw");
		for (int o = 0; o < 4; o++) begin
			add_entry(load_op(5'd11, 32'h200 + o, F3_LB), $sformatf("lb +%0d", o));
			add_entry(load_op(5'd12, 32'h200 + o, F3_LBU), $sformatf("lbu +%0d", o));
		end
		for (int o = 0; o < 4; o += 2) begin
			add_entry(load_op(5'd13, 32'h200 + o, F3_LH), $sformatf("lh +%0d", o));
			add_entry(load_op(5'd14, 32'h200 + o, F3_LHU), $sformatf("lhu +%0d", o));
		end
		add_entry(base_op(WB_ALU, 5'd7, $random(seed)), "alu");
		repeat (3) add_entry(hold_op(32'h200), "hold");
		add_entry(load_op(5'd15, 32'h200, F3_LW), "lw after hold");
		add_entry(load_op(5'd16, 32'h202, F3_LHU), "lhu");
		repeat (2) add_entry(hold_op(32'h40), "hold");
	endtask

	task automatic drive_entry(stim_t e);
		i_em_en        <= e.en;
		i_wb_src       <= e.wb_src;
		i_reg_wr_en    <= e.reg_wr_en;
		i_mem_wr_en    <= e.mem_wr_en;
		i_is_load      <= e.is_load;
		i_mem_byte_sel <= e.sel;
		i_alu_result   <= e.alu;
		i_write_data   <= e.wdata;
		i_pcplus4      <= e.pc4;
		i_pc_plus_imm  <= e.pcimm;
		i_rd_addr      <= e.rd;
		i_func3        <= e.f3;
	endtask

	task automatic report_test(string name, int bad);
		test_cnt++;
		mismatches += bad;
		if (bad != 0) begin
			fail_tests++;
			$display("test %0d %s: FAIL, %0d wrong outputs", test_cnt, name, bad);
		end else begin
			$display("test %0d %s: pass", test_cnt, name);
		end
	endtask

	task automatic check_reset();
		int bad;
		bad = 0;
		assert (o_wb_reg_wr_en === 1'b0) else begin
			$display("ERR o_wb_reg_wr_en expected %h got %h", 1'b0, o_wb_reg_wr_en);
			bad++;
		end
		assert (o_em_reg_wr_en === 1'b0) else begin
			$display("ERR o_em_reg_wr_en expected %h got %h", 1'b0, o_em_reg_wr_en);
			bad++;
		end
		assert (o_em_is_load === 1'b0) else begin
			$display("ERR o_em_is_load expected %h got %h", 1'b0, o_em_is_load);
			bad++;
		end
		report_test("reset", bad);
	endtask

	// em stage holds the entry captured at the last edge
	task automatic check_em_stage(int idx, output int bad);
		stim_t e;
		e = table_q[idx];
		bad = 0;
		assert (o_em_reg_wr_en === e.exp_wr_en) else begin
			$display("ERR o_em_reg_wr_en expected %h got %h", e.exp_wr_en, o_em_reg_wr_en);
			bad++;
		end
		assert (o_em_rd_addr === e.exp_rd) else begin
			$display("ERR o_em_rd_addr expected %h got %h", e.exp_rd, o_em_rd_addr);
			bad++;
		end
		assert (o_em_is_load === e.exp_load) else begin
			$display("ERR o_em_is_load expected %h got %h", e.exp_load, o_em_is_load);
			bad++;
		end
	endtask

	task automatic check_entry(int idx, int em_cnt);
		stim_t e;
		int    bad;
		e = table_q[idx];
		bad = em_cnt;
		assert (o_wb_reg_wr_en === e.exp_wr_en) else begin
			$display("ERR o_wb_reg_wr_en expected %h got %h", e.exp_wr_en, o_wb_reg_wr_en);
			bad++;
		end
		assert (o_wb_rd_addr === e.exp_rd) else begin
			$display("ERR o_wb_rd_addr expected %h got %h", e.exp_rd, o_wb_rd_addr);
			bad++;
		end
		assert (o_wb_data === e.exp_data) else begin
			$display("ERR o_wb_data expected %h got %h", e.exp_data, o_wb_data);
			bad++;
		end
		report_test(names[idx], bad);
	endtask

	initial begin
		i_clk = 1'b0;
		i_rstn <= 1'b0;
		drive_entry('0);
		build_table();
		cycle_limit = table_q.size() + 5 + 20;
		repeat (5) @(posedge i_clk);
		i_rstn <= 1'b1;
		@(negedge i_clk);
		check_reset();
		// entry i goes in at this edge and leaves wb two edges later
		for (int i = 0; i < table_q.size() + 2; i++) begin
			@(posedge i_clk);
			if (i < table_q.size())
				drive_entry(table_q[i]);
			else
				drive_entry('0);
			@(negedge i_clk);
			if (i >= 2)
				check_entry(i - 2, em_bad);
			if (i >= 1 && i <= table_q.size())
				check_em_stage(i - 1, em_bad);
		end
		$display("%0d tests, %0d failed, %0d wrong outputs, %0d assertion failures",
			test_cnt, fail_tests, mismatches, dut.u_assertions.fail_cnt);
		if (fail_tests == 0 && dut.u_assertions.fail_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: sources.f
hw/riscv_pkg.sv
hw/riscv_em_if.sv
hw/riscv_em_register.sv
hw/riscv_dmem.sv
hw/riscv_load_align.sv
hw/riscv_mem_wb.sv
hw/riscv_back_end.sv
sim/riscv_back_end_assertions.sv
sim/riscv_back_end_tb.sv
